// ==== led_panel_top.f ====
+incdir+bench
source/led_panel_pkg.sv
source/frame_buffer.sv
source/scan_controller.sv
source/led_panel_top.sv
bench/led_panel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the LED panel testbench

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --timescale 1ns/10ps \
	-f led_panel_top.f \
	--top-module led_panel_tb \
	-o led_panel_sim \
	&& ./obj_dir/led_panel_sim > "$log" 2>&1

# the run counts only if the testbench printed its pass line
grep -qsx "sim passed" "$log" \
	&& echo "simulation ok" \
	|| { echo "simulation failed, see $log"; exit 1; }

// ==== bench/led_panel_checks.svh ====
`ifndef led_panel_checks_svh
`define led_panel_checks_svh

// one compare task per kind of DUT result

task automatic check_pixel(
	input string test,
	input led_panel_pkg::pixel_t expected,
	input led_panel_pkg::pixel_t actual
);
	if (actual !== expected) begin
		abort_run($sformatf("MISMATCH %s: expected %h, actual %h", test, expected, actual));
	end
endtask

task automatic check_row(
	input string test,
	input logic [led_panel_pkg::row_bits-1:0] expected,
	input logic [led_panel_pkg::row_bits-1:0] actual
);
	if (actual !== expected) begin
		abort_run($sformatf("MISMATCH %s: expected %0d, actual %0d", test, expected, actual));
	end
endtask

task automatic check_col(
	input string test,
	input logic [led_panel_pkg::col_bits-1:0] expected,
	input logic [led_panel_pkg::col_bits-1:0] actual
);
	if (actual !== expected) begin
		abort_run($sformatf("MISMATCH %s: expected %0d, actual %0d", test, expected, actual));
	end
endtask

task automatic check_bit(input string test, input logic expected, input logic actual);
	if (actual !== expected) begin
		abort_run($sformatf("MISMATCH %s: expected %b, actual %b", test, expected, actual));
	end
endtask

`endif

// ==== bench/led_panel_tb.sv ====
`timescale 1ns/10ps

module led_panel_tb;

	localparam int on_cycles = 4;
	localparam int clk_period = 8;
	localparam int row_clocks = 3 * led_panel_pkg::panel_cols + 2 + on_cycles;
	localparam int frame_clocks = led_panel_pkg::scan_rows * row_clocks;
	// two checked frames and the load, two frames of slack
	localparam int limit_clocks = 4 * frame_clocks + led_panel_pkg::pixel_depth + 16;

	logic clk;
	logic rst;
	logic pix_we;
	led_panel_pkg::pixel_addr_t pix_addr;
	led_panel_pkg::pixel_t pix_data;

	logic [led_panel_pkg::row_bits-1:0] row_addr;
	logic [led_panel_pkg::col_bits-1:0] col_addr;
	logic display_clk;
	logic latch;
	logic display_blank;
	led_panel_pkg::pixel_t dout_a;
	led_panel_pkg::pixel_t dout_b;

	led_panel_pkg::pixel_t image [0:led_panel_pkg::pixel_depth-1]; // expected buffer contents

	led_panel_top #(
		.on_cycles(on_cycles)
	) i_led_panel_top (
		.clk(clk),
		.rst(rst),
		.pix_we(pix_we),
		.pix_addr(pix_addr),
		.pix_data(pix_data),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.display_clk(display_clk),
		.latch(latch),
		.display_blank(display_blank),
		.dout_a(dout_a),
		.dout_b(dout_b)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "led_panel_checks.svh"

	function automatic logic [led_panel_pkg::row_bits-1:0] row_of(input int r);
		return r[led_panel_pkg::row_bits-1:0];
	endfunction

	function automatic logic [led_panel_pkg::col_bits-1:0] col_of(input int c);
		return c[led_panel_pkg::col_bits-1:0];
	endfunction

	// half on top, then row, then column
	function automatic led_panel_pkg::pixel_addr_t word_of(
		input logic half,
		input logic [led_panel_pkg::row_bits-1:0] row,
		input logic [led_panel_pkg::col_bits-1:0] col
	);
		led_panel_pkg::pixel_addr_t w;
		w.flat = {half, row, col};
		return w;
	endfunction

	task automatic write_pixel(input led_panel_pkg::pixel_addr_t addr,
		input led_panel_pkg::pixel_t data);
		image[addr.flat] = data;
		pix_we = 1'b1;
		pix_addr = addr;
		pix_data = data;
		@(negedge clk);
		pix_we = 1'b0;
	endtask

	// next display_clk pulse at the given row and column
	task automatic wait_for_pulse(
		input string test,
		input logic [led_panel_pkg::row_bits-1:0] row,
		input logic [led_panel_pkg::col_bits-1:0] col
	);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!(display_clk && row_addr == row && col_addr == col)) begin
			waited++;
			if (waited > 2 * frame_clocks) begin
				abort_run({test, ": no shift pulse at the awaited row and column"});
			end
			@(negedge clk);
		end
	endtask

	// display_clk low until the gap-th clock, high there
	task automatic expect_pulse_after(input string test, input int gap);
		for (int n = 1; n <= gap; n++) begin
			@(negedge clk);
			check_bit({test, " display_clk"}, (n == gap), display_clk);
		end
	endtask

	task automatic check_pulse(
		input string test,
		input logic [led_panel_pkg::row_bits-1:0] row,
		input logic [led_panel_pkg::col_bits-1:0] col
	);
		led_panel_pkg::pixel_addr_t upper;
		led_panel_pkg::pixel_addr_t lower;
		upper = word_of(1'b0, row, col);
		lower = word_of(1'b1, row, col);
		check_row({test, " row_addr"}, row, row_addr);
		check_col({test, " col_addr"}, col, col_addr);
		check_pixel({test, " dout_a"}, image[upper.flat], dout_a);
		check_pixel({test, " dout_b"}, image[lower.flat], dout_b);
	endtask

	task automatic reset_state();
		for (int n = 0; n <= 15; n++) begin
			@(negedge clk);
			if (n == 15) begin
				rst = 1'b0; // outputs hold until the next rising edge
			end
			check_bit("reset_state display_clk", 1'b0, display_clk);
			check_bit("reset_state latch", 1'b0, latch);
			check_bit("reset_state fbuf_re", 1'b0, i_led_panel_top.fbuf_re);
			check_bit("reset_state display_blank", 1'b1, display_blank);
			check_row("reset_state row_addr", '0, row_addr);
			check_col("reset_state col_addr", '0, col_addr);
			check_pixel("reset_state dout_a", '0, dout_a);
			check_pixel("reset_state dout_b", '0, dout_b);
		end
	endtask

	task automatic load_image();
		led_panel_pkg::pixel_addr_t addr;
		int unsigned rnd;
		for (int i = 0; i < led_panel_pkg::pixel_depth; i++) begin
			rnd = $urandom();
			addr.flat = i[led_panel_pkg::addr_bits-1:0];
			write_pixel(addr, rnd[led_panel_pkg::pixel_bits-1:0]);
		end
		wait_for_pulse("load_image", '0, '0); // start of a fresh frame
	endtask

	task automatic shift_data();
		for (int r = 0; r < led_panel_pkg::scan_rows; r++) begin
			for (int c = 0; c < led_panel_pkg::panel_cols; c++) begin
				if (c != 0) begin
					expect_pulse_after("shift_data", 3);
				end else if (r != 0) begin
					expect_pulse_after("shift_data row gap", on_cycles + 5);
				end
				check_pulse("shift_data", row_of(r), col_of(c));
			end
		end
	endtask

	task automatic latch_and_lit();
		logic [led_panel_pkg::row_bits-1:0] row;
		logic [led_panel_pkg::row_bits-1:0] next_row;
		row = row_of(led_panel_pkg::scan_rows - 1); // last row of the checked frame
		next_row = row_of((int'(row) + 1) % led_panel_pkg::scan_rows);
		@(negedge clk);
		check_bit("latch_and_lit latch", 1'b0, latch);
		check_bit("latch_and_lit display_blank", 1'b1, display_blank);
		repeat (2) begin
			@(negedge clk);
			check_bit("latch_and_lit latch", 1'b1, latch);
			check_bit("latch_and_lit display_blank", 1'b1, display_blank);
			check_row("latch_and_lit row_addr", row, row_addr);
		end
		repeat (on_cycles) begin
			@(negedge clk);
			check_bit("latch_and_lit latch", 1'b0, latch);
			check_bit("latch_and_lit display_blank", 1'b0, display_blank);
			check_row("latch_and_lit row_addr", row, row_addr);
		end
		@(negedge clk);
		check_bit("latch_and_lit display_blank", 1'b1, display_blank);
		check_row("latch_and_lit next row", next_row, row_addr);
		@(negedge clk);
		check_bit("latch_and_lit display_clk", 1'b1, display_clk);
		check_col("latch_and_lit col_addr", '0, col_addr);
	endtask

	task automatic live_update();
		led_panel_pkg::pixel_addr_t upper;
		led_panel_pkg::pixel_addr_t lower;
		logic [led_panel_pkg::row_bits-1:0] row;
		logic [led_panel_pkg::col_bits-1:0] col;
		int unsigned rnd;
		rnd = $urandom();
		row = row_of(8 + int'(rnd % 16)); // well ahead of the scan
		rnd = $urandom();
		col = col_of(int'(rnd % led_panel_pkg::panel_cols));
		upper = word_of(1'b0, row, col);
		lower = word_of(1'b1, row, col);
		write_pixel(upper, ~image[upper.flat]);
		write_pixel(lower, ~image[lower.flat]);
		wait_for_pulse("live_update", row, col);
		check_pulse("live_update", row, col);
		wait_for_pulse("live_update", row_of(led_panel_pkg::scan_rows - 1),
			col_of(led_panel_pkg::panel_cols - 1));
		expect_pulse_after("live_update wrap", on_cycles + 5);
		check_pulse("live_update wrap", '0, '0);
	endtask

	initial begin
		#(limit_clocks * clk_period);
		abort_run("watchdog expired, the panel scan stalled");
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		pix_we = 1'b0;
		pix_addr = '0;
		pix_data = '0;
		void'($urandom(32'h9b78_f906));
		reset_state();
		load_image();
		shift_data();
		latch_and_lit();
		live_update();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== source/led_panel_top.sv ====
`timescale 1ns/10ps

module led_panel_top #(
	parameter int on_cycles = 4 // lit clocks per row
) (
	input logic clk,
	input logic rst,

	// pixel write, single cycle strobe
	input logic pix_we,
	input led_panel_pkg::pixel_addr_t pix_addr,
	input led_panel_pkg::pixel_t pix_data,

	// panel side
	output logic [led_panel_pkg::row_bits-1:0] row_addr,
	output logic [led_panel_pkg::col_bits-1:0] col_addr,
	output logic display_clk,
	output logic latch,
	output logic display_blank,
	output led_panel_pkg::pixel_t dout_a, // upper half pixel
	output led_panel_pkg::pixel_t dout_b // lower half pixel
);

	logic fbuf_re; // scan read strobe

	frame_buffer i_frame_buffer (
		.clk(clk),
		.rst(rst),
		.pix_we(pix_we),
		.pix_addr(pix_addr),
		.pix_data(pix_data),
		.fbuf_re(fbuf_re),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.dout_a(dout_a),
		.dout_b(dout_b)
	);

	scan_controller #(
		.on_cycles(on_cycles)
	) i_scan_controller (
		.clk(clk),
		.rst(rst),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.fbuf_re(fbuf_re),
		.display_clk(display_clk),
		.latch(latch),
		.display_blank(display_blank)
	);

endmodule

// ==== source/scan_controller.sv ====
`timescale 1ns/10ps

module scan_controller #(
	parameter int on_cycles = 4 // clocks a latched row stays lit
) (
	input logic clk,
	input logic rst,

	output logic [led_panel_pkg::row_bits-1:0] row_addr,
	output logic [led_panel_pkg::col_bits-1:0] col_addr,
	output logic fbuf_re,
	output logic display_clk,
	output logic latch,
	output logic display_blank
);

	// state names the phase that starts at the coming edge
	localparam logic [2:0] fetch = 3'd0;
	localparam logic [2:0] shift_high = 3'd1;
	localparam logic [2:0] shift_low = 3'd2;
	localparam logic [2:0] latch_high = 3'd3;
	localparam logic [2:0] latch_low = 3'd4;
	localparam logic [2:0] lit = 3'd5;

	localparam int cnt_bits = (on_cycles < 1) ? 1 : $clog2(on_cycles + 1);

	localparam logic [led_panel_pkg::col_bits-1:0] last_col =
		led_panel_pkg::col_bits'(led_panel_pkg::panel_cols - 1);
	localparam logic [led_panel_pkg::row_bits-1:0] last_row =
		led_panel_pkg::row_bits'(led_panel_pkg::scan_rows - 1);
	localparam logic [cnt_bits-1:0] lit_end = cnt_bits'(on_cycles);

	logic [2:0] state;
	logic [cnt_bits-1:0] lit_cnt; // edges spent in lit

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= fetch;
			row_addr <= '0;
			col_addr <= '0;
			fbuf_re <= 1'b0;
			display_clk <= 1'b0;
			latch <= 1'b0;
			display_blank <= 1'b1;
			lit_cnt <= '0;
		end else begin
			case (state)
				fetch: begin
					fbuf_re <= 1'b1; // buffer reads at the end of this phase
					display_clk <= 1'b0;
					latch <= 1'b0;
					display_blank <= 1'b1;
					state <= shift_high;
				end

				shift_high: begin
					fbuf_re <= 1'b0;
					display_clk <= 1'b1; // pixel pair valid on dout
					state <= shift_low;
				end

				shift_low: begin
					display_clk <= 1'b0;
					if (col_addr == last_col) begin
						col_addr <= '0;
						state <= latch_high;
					end else begin
						col_addr <= col_addr + 1'b1;
						state <= fetch;
					end
				end

				latch_high: begin
					latch <= 1'b1;
					state <= latch_low;
				end

				latch_low: begin
					latch <= 1'b1; // second latch clock
					state <= lit;
				end

				lit: begin
					latch <= 1'b0;
					if (lit_cnt == lit_end) begin
						// blank again, next row, phase 0 right away
						lit_cnt <= '0;
						display_blank <= 1'b1;
						fbuf_re <= 1'b1;
						state <= shift_high;
						if (row_addr == last_row) begin
							row_addr <= '0;
						end else begin
							row_addr <= row_addr + 1'b1;
						end
					end else begin
						lit_cnt <= lit_cnt + 1'b1;
						display_blank <= 1'b0; // row on
					end
				end

				default: begin
					state <= fetch;
					fbuf_re <= 1'b0;
					display_clk <= 1'b0;
					latch <= 1'b0;
					display_blank <= 1'b1;
					lit_cnt <= '0;
				end
			endcase
		end
	end

endmodule

// ==== source/frame_buffer.sv ====
`timescale 1ns/10ps

module frame_buffer (
	input logic clk,
	input logic rst,

	// pixel write side
	input logic pix_we,
	input led_panel_pkg::pixel_addr_t pix_addr,
	input led_panel_pkg::pixel_t pix_data,

	// scan read side
	input logic fbuf_re,
	input logic [led_panel_pkg::row_bits-1:0] row_addr,
	input logic [led_panel_pkg::col_bits-1:0] col_addr,

	output led_panel_pkg::pixel_t dout_a,
	output led_panel_pkg::pixel_t dout_b
);

	// two copies of the image, one read port each
	led_panel_pkg::pixel_t mem_a [0:led_panel_pkg::pixel_depth-1];
	led_panel_pkg::pixel_t mem_b [0:led_panel_pkg::pixel_depth-1];

	led_panel_pkg::pixel_addr_t raddr_a; // upper half word
	led_panel_pkg::pixel_addr_t raddr_b; // lower half word

	// same row and column, half bit picks the panel half
	always_comb begin
		raddr_a.field.half = 1'b0;
		raddr_a.field.row = row_addr;
		raddr_a.field.col = col_addr;

		raddr_b.field.half = 1'b1;
		raddr_b.field.row = row_addr;
		raddr_b.field.col = col_addr;
	end

	// every write lands in both copies
	always_ff @(posedge clk) begin
		if (pix_we) begin
			mem_a[pix_addr.flat] <= pix_data;
			mem_b[pix_addr.flat] <= pix_data;
		end
	end

	// read before write on a same-word hit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dout_a <= '0;
			dout_b <= '0;
		end else if (fbuf_re) begin
			dout_a <= mem_a[raddr_a.flat];
			dout_b <= mem_b[raddr_b.flat];
		end
	end

endmodule

// ==== source/led_panel_pkg.sv ====
package led_panel_pkg;

	localparam int panel_cols = 64; // columns per scan row
	localparam int scan_rows = 32; // rows per panel half

	localparam int col_bits = 6;
	localparam int row_bits = 5;

	// half bit on top of row and column
	localparam int addr_bits = 1 + row_bits + col_bits;

	localparam int pixel_depth = 4096; // both halves, 2 x 32 x 64

	localparam int pixel_bits = 4;

	// bit 0 red, bit 1 green, bit 2 blue
	// bit 3 spare, goes out to the panel as written
	typedef logic [pixel_bits-1:0] pixel_t;

	// Buffer address. The write port sees a flat word index, the scan side
	// builds the same word from half, row and column.
	typedef union packed {
		logic [addr_bits-1:0] flat; // word index into the buffer

		struct packed {
			logic half; // 0 upper half, 1 lower half
			logic [row_bits-1:0] row; // scan row within the half
			logic [col_bits-1:0] col; // column within the row
		} field;
	} pixel_addr_t;

endpackage
